// File: mlkem_mask_pkg.sv
// ML-KEM masked conditional subtraction package
// Modulus, share widths and pipeline depths shared by every block
// of the first-order masked subtraction stage

`default_nettype none

package mlkem_mask_pkg;

    // ------------------------------
    // Modulus
    // ------------------------------
    localparam int q_width = 12;
    localparam logic [q_width-1:0] mlkem_q = 12'd3329;

    // Arithmetic shares are summed modulo 2^share_width
    localparam int share_width = 14;

    // ------------------------------
    // Latency
    // ------------------------------
    // Depth of the condition path and of the refresh pipe
    localparam int cond_latency = 3;
    // Input strobe to output strobe, one more for the combiner register
    localparam int total_latency = cond_latency + 1;

    // Two arithmetic or Boolean shares, index 0 and 1
    typedef logic [1:0][share_width-1:0] share_t;

endpackage

`default_nettype wire

// File: masked_share_if.sv
// Masked share bus
// Carries a one-cycle valid strobe and two arithmetic shares of one
// coefficient from one pipeline stage to the next

`default_nettype none

interface masked_share_if;

    // Shares only meaningful while valid is high
    logic                                   valid;
    logic [mlkem_mask_pkg::share_width-1:0] share0;
    logic [mlkem_mask_pkg::share_width-1:0] share1;

    // Producing stage
    modport src (output valid, output share0, output share1);

    // Consuming stage
    modport dst (input valid, input share0, input share1);

endinterface

`default_nettype wire

// File: barrett_rnd_if.sv
// Randomness bus for the masked condition path
// Fresh values every cycle from the external entropy source,
// no handshake

`default_nettype none

interface barrett_rnd_if;

    // Refresh of the shared condition bit
    logic                                   rnd_bit;
    // Boolean split of q
    logic [mlkem_mask_pkg::q_width-1:0]     rnd_q;
    // One mask bit per DOM AND gate
    logic [mlkem_mask_pkg::share_width-1:0] rnd_and;
    // Gamma for the B2A conversion
    logic [mlkem_mask_pkg::share_width-1:0] rnd_b2a;

    modport src (output rnd_bit, output rnd_q, output rnd_and, output rnd_b2a);
    modport dst (input rnd_bit, input rnd_q, input rnd_and, input rnd_b2a);

endinterface

`default_nettype wire

// File: masked_and.sv
// First-order domain-oriented masked AND
// Two Boolean-shared bits in, one Boolean-shared bit out
// Cross-domain terms are remasked before the register stage,
// one cycle of latency

`default_nettype none

module masked_and (
    input  logic       clk,
    input  logic       reset,
    input  logic       zeroize,
    input  logic [1:0] x,
    input  logic [1:0] y,
    input  logic       rnd,
    output logic [1:0] z
);

    // Inner-domain products
    logic p00_q;
    logic p11_q;
    // Masked cross-domain products
    logic p01_q;
    logic p10_q;

    // ------------------------------
    // Product register
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset || zeroize) begin
            p00_q <= 1'b0;
            p11_q <= 1'b0;
            p01_q <= 1'b0;
            p10_q <= 1'b0;
        end else begin
            p00_q <= x[0] & y[0];
            p11_q <= x[1] & y[1];
            // Same mask on both cross terms, it cancels in the output sum
            p01_q <= (x[0] & y[1]) ^ rnd;
            p10_q <= (x[1] & y[0]) ^ rnd;
        end
    end

    // Domain integration only after the register
    assign z[0] = p00_q ^ p01_q;
    assign z[1] = p11_q ^ p10_q;

endmodule

`default_nettype wire

// File: masked_b2a.sv
// Masked Boolean-to-arithmetic conversion
// Goubin-style first-order conversion of a Boolean-shared word into
// two arithmetic shares modulo 2^14
// Stage one forms the two masked terms, stage two combines them,
// result two cycles after the input

`default_nettype none

module masked_b2a (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   zeroize,
    input  mlkem_mask_pkg::share_t                 x_bool,
    input  logic [mlkem_mask_pkg::share_width-1:0] rnd,
    output mlkem_mask_pkg::share_t                 x_arith
);

    // Masked operands for the affine function phi(a) = (x0 ^ a) - a
    logic [mlkem_mask_pkg::share_width-1:0] gamma_mix;

    // Stage one registers
    logic [mlkem_mask_pkg::share_width-1:0] t1_q;
    logic [mlkem_mask_pkg::share_width-1:0] t2_q;
    logic [mlkem_mask_pkg::share_width-1:0] x0_q;
    logic [mlkem_mask_pkg::share_width-1:0] x1_q;

    // Second Boolean share hidden by gamma
    assign gamma_mix = x_bool[1] ^ rnd;

    // ------------------------------
    // Stage one
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset || zeroize) begin
            t1_q <= '0;
            t2_q <= '0;
            x0_q <= '0;
            x1_q <= '0;
        end else begin
            // phi(gamma)
            t1_q <= (x_bool[0] ^ rnd) - rnd;
            // phi(x1 ^ gamma)
            t2_q <= (x_bool[0] ^ gamma_mix) - gamma_mix;
            x0_q <= x_bool[0];
            x1_q <= x_bool[1];
        end
    end

    // ------------------------------
    // Stage two
    // ------------------------------
    // phi is affine over GF(2), so phi(x1) = phi(gamma) ^ phi(x1 ^ gamma) ^ x0
    // and phi(x1) + x1 gives back x0 ^ x1
    always_ff @(posedge clk) begin
        if (reset || zeroize) begin
            x_arith <= '0;
        end else begin
            x_arith[0] <= t1_q ^ t2_q ^ x0_q;
            x_arith[1] <= x1_q;
        end
    end

endmodule

`default_nettype wire

// File: barrett_if_cond.sv
// Masked condition path of the conditional subtraction
// Tests whether the shared coefficient is at least 2^12 and returns
// arithmetic shares of q when it is, of zero otherwise
// One cycle of DOM AND, two cycles of B2A, three cycles in total

`default_nettype none

module barrett_if_cond (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   zeroize,
    input  mlkem_mask_pkg::share_t c_in,
    barrett_rnd_if.dst             rnd,
    output mlkem_mask_pkg::share_t q_shares
);

    // Unmasked sum, only used for its two top bits
    logic [mlkem_mask_pkg::share_width-1:0] c_sum;
    logic                                   c_ge;
    // Condition as a refreshed Boolean pair
    logic [1:0]                             cond_bool;
    // q zero-extended and split into Boolean shares
    mlkem_mask_pkg::share_t                 q_bool;
    // Per-bit AND outputs, then packed back into a word pair
    logic [1:0]                             and_out [mlkem_mask_pkg::share_width];
    mlkem_mask_pkg::share_t                 and_bool;

    // ------------------------------
    // Condition bit
    // ------------------------------
    always_comb begin
        c_sum = c_in[0] + c_in[1];
        // c >= 4096 when bit 12 or bit 13 is set
        c_ge = c_sum[12] | c_sum[13];
        cond_bool[0] = c_ge ^ rnd.rnd_bit;
        cond_bool[1] = rnd.rnd_bit;
    end

    // Boolean split of q, top two bits stay zero in both shares
    always_comb begin
        q_bool[0] = {2'b00, mlkem_mask_pkg::mlkem_q ^ rnd.rnd_q};
        q_bool[1] = {2'b00, rnd.rnd_q};
    end

    // ------------------------------
    // Bitwise masked AND with the condition
    // ------------------------------
    for (genvar i = 0; i < mlkem_mask_pkg::share_width; i++) begin : gen_and
        masked_and u_and (
            .clk     (clk),
            .reset   (reset),
            .zeroize (zeroize),
            .x       (cond_bool),
            .y       ({q_bool[1][i], q_bool[0][i]}),
            .rnd     (rnd.rnd_and[i]),
            .z       (and_out[i])
        );
    end

    // Bit pairs back into one word per share
    always_comb begin
        for (int i = 0; i < mlkem_mask_pkg::share_width; i++) begin
            and_bool[0][i] = and_out[i][0];
            and_bool[1][i] = and_out[i][1];
        end
    end

    // Boolean shares of q or zero into arithmetic shares
    masked_b2a u_b2a (
        .clk     (clk),
        .reset   (reset),
        .zeroize (zeroize),
        .x_bool  (and_bool),
        .rnd     (rnd.rnd_b2a),
        .x_arith (q_shares)
    );

endmodule

`default_nettype wire

// File: share_refresh_pipe.sv
// Share refresh pipeline
// Delays the input shares and valid by the depth of the condition
// path and remasks the pair at every stage with a fresh slice

`default_nettype none

module share_refresh_pipe (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   zeroize,
    input  logic                   valid_in,
    input  mlkem_mask_pkg::share_t c_in,
    input  logic [mlkem_mask_pkg::cond_latency*mlkem_mask_pkg::share_width-1:0] rnd_refresh,
    masked_share_if.src            pipe_out
);

    // Valid shift register, index 0 is the first stage
    logic [mlkem_mask_pkg::cond_latency-1:0] vld_q;
    mlkem_mask_pkg::share_t                  stage_q [mlkem_mask_pkg::cond_latency];
    // Per-stage remask value
    logic [mlkem_mask_pkg::share_width-1:0]  mask [mlkem_mask_pkg::cond_latency];

    always_comb begin
        for (int k = 0; k < mlkem_mask_pkg::cond_latency; k++) begin
            mask[k] = rnd_refresh[k*mlkem_mask_pkg::share_width +: mlkem_mask_pkg::share_width];
        end
    end

    // ------------------------------
    // Stages
    // ------------------------------
    // Add to share0, subtract from share1, sum mod 2^14 unchanged
    always_ff @(posedge clk) begin
        if (reset || zeroize) begin
            vld_q <= '0;
            for (int k = 0; k < mlkem_mask_pkg::cond_latency; k++) begin
                stage_q[k] <= '0;
            end
        end else begin
            vld_q <= {vld_q[mlkem_mask_pkg::cond_latency-2:0], valid_in};
            stage_q[0][0] <= c_in[0] + mask[0];
            stage_q[0][1] <= c_in[1] - mask[0];
            for (int k = 1; k < mlkem_mask_pkg::cond_latency; k++) begin
                stage_q[k][0] <= stage_q[k-1][0] + mask[k];
                stage_q[k][1] <= stage_q[k-1][1] - mask[k];
            end
        end
    end

    // Last stage onto the bus
    assign pipe_out.valid  = vld_q[mlkem_mask_pkg::cond_latency-1];
    assign pipe_out.share0 = stage_q[mlkem_mask_pkg::cond_latency-1][0];
    assign pipe_out.share1 = stage_q[mlkem_mask_pkg::cond_latency-1][1];

endmodule

`default_nettype wire

// File: cond_sub_combine.sv
// Conditional subtraction combiner
// Subtracts the masked q shares from the delayed coefficient shares,
// share by share modulo 2^14, and registers the result with valid

`default_nettype none

module cond_sub_combine (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   zeroize,
    masked_share_if.dst            pipe_in,
    input  mlkem_mask_pkg::share_t q_shares,
    output logic                   valid_out,
    output mlkem_mask_pkg::share_t c_out
);

    // ------------------------------
    // Output register
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset || zeroize) begin
            valid_out <= 1'b0;
            c_out     <= '0;
        end else begin
            valid_out <= pipe_in.valid;
            // Shares only move on a valid word, otherwise hold the last result
            if (pipe_in.valid) begin
                // Domains never mix, each share loses its own q share
                c_out[0] <= pipe_in.share0 - q_shares[0];
                c_out[1] <= pipe_in.share1 - q_shares[1];
            end
        end
    end

endmodule

`default_nettype wire

// File: mlkem_cond_sub.sv
// ML-KEM masked conditional subtraction, top level
// Subtracts q = 3329 from a two-share coefficient when it is >= 4096
// Masked condition path and share refresh pipe run side by side,
// combiner joins them, four cycles from valid_in to valid_out

`default_nettype none

module mlkem_cond_sub (
    input  logic        clk,
    input  logic        reset,
    input  logic        zeroize,
    input  logic        valid_in,
    input  logic [13:0] c_share0,
    input  logic [13:0] c_share1,
    input  logic        rnd_bit,
    input  logic [11:0] rnd_q,
    input  logic [13:0] rnd_and,
    input  logic [13:0] rnd_b2a,
    input  logic [41:0] rnd_refresh,
    output logic        valid_out,
    output logic [13:0] out_share0,
    output logic [13:0] out_share1
);

    mlkem_mask_pkg::share_t c_in;
    mlkem_mask_pkg::share_t q_shares;
    mlkem_mask_pkg::share_t c_out;

    barrett_rnd_if  rnd_bus ();
    masked_share_if pipe_out ();

    // ------------------------------
    // Port mapping
    // ------------------------------
    assign c_in            = {c_share1, c_share0};
    assign rnd_bus.rnd_bit = rnd_bit;
    assign rnd_bus.rnd_q   = rnd_q;
    assign rnd_bus.rnd_and = rnd_and;
    assign rnd_bus.rnd_b2a = rnd_b2a;
    assign out_share0      = c_out[0];
    assign out_share1      = c_out[1];

    // Shares of q or of zero, three cycles
    barrett_if_cond u_cond (
        .clk      (clk),
        .reset    (reset),
        .zeroize  (zeroize),
        .c_in     (c_in),
        .rnd      (rnd_bus.dst),
        .q_shares (q_shares)
    );

    // Delayed and remasked coefficient, same depth
    share_refresh_pipe u_pipe (
        .clk         (clk),
        .reset       (reset),
        .zeroize     (zeroize),
        .valid_in    (valid_in),
        .c_in        (c_in),
        .rnd_refresh (rnd_refresh),
        .pipe_out    (pipe_out.src)
    );

    cond_sub_combine u_combine (
        .clk       (clk),
        .reset     (reset),
        .zeroize   (zeroize),
        .pipe_in   (pipe_out.dst),
        .q_shares  (q_shares),
        .valid_out (valid_out),
        .c_out     (c_out)
    );

endmodule

`default_nettype wire

// File: mlkem_cond_sub_props.sv
// Concurrent checks on the masked conditional subtraction top level
// Latency of the valid strobe, output clearing under reset and zeroize
// Bound into every instance of mlkem_cond_sub

`default_nettype none

module mlkem_cond_sub_props (
    input logic        clk,
    input logic        reset,
    input logic        zeroize,
    input logic        valid_in,
    input logic        valid_out,
    input logic [13:0] out_share0,
    input logic [13:0] out_share1
);

    // Failed assertions so far, read by the testbench
    int fail_count = 0;

    // ------------------------------
    // Strobe latency
    // ------------------------------
    // Every accepted word comes out total_latency cycles later
    a_valid_follows: assert property (@(posedge clk) disable iff (reset || zeroize)
        valid_in |-> ##(mlkem_mask_pkg::total_latency) valid_out)
    else begin
        fail_count++;
        $error("valid_out missing after valid_in");
    end

    // No output strobe without a word total_latency cycles before
    a_valid_origin: assert property (@(posedge clk) disable iff (reset)
        valid_out |-> $past(valid_in, mlkem_mask_pkg::total_latency))
    else begin
        fail_count++;
        $error("valid_out without a matching valid_in");
    end

    // ------------------------------
    // Clearing
    // ------------------------------
    a_reset_clear: assert property (@(posedge clk)
        reset |=> (!valid_out && out_share0 == 14'd0 && out_share1 == 14'd0))
    else begin
        fail_count++;
        $error("outputs not cleared by reset");
    end

    a_zeroize_clear: assert property (@(posedge clk)
        zeroize |=> (!valid_out && out_share0 == 14'd0 && out_share1 == 14'd0))
    else begin
        fail_count++;
        $error("outputs not cleared by zeroize");
    end

endmodule

bind mlkem_cond_sub mlkem_cond_sub_props i_props (
    .clk        (clk),
    .reset      (reset),
    .zeroize    (zeroize),
    .valid_in   (valid_in),
    .valid_out  (valid_out),
    .out_share0 (out_share0),
    .out_share1 (out_share1)
);

`default_nettype wire

// File: tb_mlkem_cond_sub.sv
// Testbench for the ML-KEM masked conditional subtraction
// Random masked coefficients below and above 4096, edge values, bursts,
// isolated words, zeroize in mid-stream and output clearing after reset
// Expected share sums come from a reference model of the subtraction rule

`default_nettype none

module tb_mlkem_cond_sub;

    localparam int cycle_limit = 1200;

    logic        clk;
    logic        reset;
    logic        zeroize;
    logic        valid_in;
    logic [13:0] c_share0;
    logic [13:0] c_share1;
    logic        rnd_bit;
    logic [11:0] rnd_q;
    logic [13:0] rnd_and;
    logic [13:0] rnd_b2a;
    logic [41:0] rnd_refresh;
    logic        valid_out;
    logic [13:0] out_share0;
    logic [13:0] out_share1;

    logic [31:0] rng_state;
    int unsigned cyc = 0;
    // Expected results in flight as due cycle and share sum
    int unsigned due_q [$];
    logic [13:0] exp_q [$];
    // Set by reset or zeroize until the next result
    logic        zero_expected = 1'b0;
    int unsigned n_sent = 0;
    int unsigned n_checked = 0;
    int unsigned n_dropped = 0;

    mlkem_cond_sub i_dut (
        .clk         (clk),
        .reset       (reset),
        .zeroize     (zeroize),
        .valid_in    (valid_in),
        .c_share0    (c_share0),
        .c_share1    (c_share1),
        .rnd_bit     (rnd_bit),
        .rnd_q       (rnd_q),
        .rnd_and     (rnd_and),
        .rnd_b2a     (rnd_b2a),
        .rnd_refresh (rnd_refresh),
        .valid_out   (valid_out),
        .out_share0  (out_share0),
        .out_share1  (out_share1)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        return next_rand() % n;
    endfunction

    // Subtract q once when c >= 4096 with wrap modulo 2^14
    function automatic logic [13:0] ref_cond_sub(input logic [13:0] c);
        if (c[12] || c[13]) begin
            return c - 14'd3329;
        end
        return c;
    endfunction

    function automatic logic [13:0] edge_value(input int idx);
        case (idx)
            0: return 14'd0;
            1: return 14'd3328;
            2: return 14'd3329;
            3: return 14'd4095;
            4: return 14'd4096;
            default: return 14'd6657;
        endcase
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_sum(input mlkem_mask_pkg::share_t got, input logic [13:0] exp);
        logic [13:0] sum;
        sum = got[0] + got[1];
        if (sum !== exp) begin
            abort_run($sformatf("[ERROR] t=%0t out_share0+out_share1 got %h expected %h",
                $time, sum, exp));
        end
    endtask

    task automatic check_valid(input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] t=%0t valid_out got %b expected %b", $time, got, exp));
        end
    endtask

    task automatic check_share(input string name, input logic [13:0] got,
                               input logic [13:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] t=%0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    // One falling edge with fresh masks and randomness
    task automatic drive_cycle(input logic v, input logic [13:0] c, input logic z);
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        @(negedge clk);
        r0 = next_rand();
        r1 = next_rand();
        r2 = next_rand();
        r3 = next_rand();
        valid_in    = v;
        zeroize     = z;
        c_share0    = r0[13:0];
        c_share1    = c - r0[13:0];
        rnd_bit     = r0[31];
        rnd_q       = r0[27:16];
        rnd_and     = r1[13:0];
        rnd_b2a     = r1[29:16];
        rnd_refresh = {r3[9:0], r2};
    endtask

    task automatic send_word(input logic [13:0] c);
        drive_cycle(1'b1, c, 1'b0);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_cycle(1'b0, 14'(rand_below(16384)), 1'b0);
    endtask

    // ------------------------------
    // Cycle count, timeout and reference model
    // ------------------------------
    always @(posedge clk) begin
        logic [13:0] c_sum;
        cyc = cyc + 1;
        c_sum = c_share0 + c_share1;
        if (cyc >= cycle_limit) begin
            abort_run("timeout: the run did not finish within the cycle limit");
        end else if (i_dut.i_props.fail_count != 0) begin
            abort_run("a concurrent assertion on the DUT failed");
        end else if (reset || zeroize) begin
            // Words in flight are lost
            n_dropped += due_q.size();
            due_q.delete();
            exp_q.delete();
            zero_expected = 1'b1;
        end else if (valid_in) begin
            // Output register loads at edge n+3, seen high at edge n+4
            due_q.push_back(cyc + mlkem_mask_pkg::total_latency - 1);
            exp_q.push_back(ref_cond_sub(c_sum));
            n_sent++;
        end
    end

    // Compare on the falling edge where outputs are stable
    always @(negedge clk) begin
        logic exp_valid;
        exp_valid = (due_q.size() > 0) && (due_q[0] == cyc);
        // Outputs are unknown before the first rising edge
        if (cyc > 0) begin
            check_valid(valid_out, exp_valid);
            if (exp_valid) begin
                check_sum({out_share1, out_share0}, exp_q[0]);
                void'(due_q.pop_front());
                void'(exp_q.pop_front());
                n_checked++;
                zero_expected = 1'b0;
            end else if (zero_expected) begin
                check_share("out_share0", out_share0, 14'd0);
                check_share("out_share1", out_share1, 14'd0);
            end
        end
    end

    // ------------------------------
    // Stimulus
    // ------------------------------
    initial begin
        rng_state   = 32'hbf0c_593d;
        reset       = 1'b1;
        zeroize     = 1'b0;
        valid_in    = 1'b0;
        c_share0    = 14'd0;
        c_share1    = 14'd0;
        rnd_bit     = 1'b0;
        rnd_q       = 12'd0;
        rnd_and     = 14'd0;
        rnd_b2a     = 14'd0;
        rnd_refresh = 42'd0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Outputs stay zero until the first result
        idle_cycles(8);

        // Burst below 4096 keeps the sum
        repeat (150) send_word(14'(rand_below(4096)));
        // Burst from 4096 to 6657 loses q
        repeat (150) send_word(14'(4096 + rand_below(2562)));
        idle_cycles(3);

        // Edge values under fresh masks
        for (int k = 0; k < 24; k++) begin
            send_word(edge_value(k % 6));
            idle_cycles(rand_below(4));
        end

        // Isolated words
        repeat (30) begin
            send_word(14'(rand_below(6658)));
            idle_cycles(1 + rand_below(6));
        end

        // Mixed traffic with about half the cycles carrying a word
        repeat (300) drive_cycle(1'(rand_below(2)), 14'(rand_below(6658)), 1'b0);

        // Zeroize in mid-stream and recovery
        for (int k = 0; k < 24; k++) begin
            drive_cycle(1'b1, 14'(rand_below(6658)), (k >= 8 && k < 11));
        end
        idle_cycles(5);
        repeat (20) send_word(14'(rand_below(6658)));

        idle_cycles(mlkem_mask_pkg::total_latency + 4);

        if (due_q.size() == 0 && n_checked > 0 && n_checked + n_dropped == n_sent
                && i_dut.i_props.fail_count == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            abort_run($sformatf("results missing: %0d sent, %0d checked, %0d dropped",
                n_sent, n_checked, n_dropped));
        end
    end

endmodule

`default_nettype wire

// File: src.f
mlkem_mask_pkg.sv
masked_share_if.sv
barrett_rnd_if.sv
masked_and.sv
masked_b2a.sv
barrett_if_cond.sv
share_refresh_pipe.sv
cond_sub_combine.sv
mlkem_cond_sub.sv
mlkem_cond_sub_props.sv
tb_mlkem_cond_sub.sv
